//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// cpu and external memory bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// one data word, also the cache line payload
	typedef logic [DATA_W-1:0] word_t;

endpackage

`default_nettype wire

//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

	import mem_pkg::*;

	// direct mapped, one word per line
	localparam int TAG_W = 22;
	localparam int INDEX_W = 8;
	localparam int OFFSET_W = ADDR_W - TAG_W - INDEX_W;
	localparam int LINES = 1 << INDEX_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// per line metadata, kept apart from the data word
	typedef struct packed
	{
		logic valid;
		logic dirty;
		tag_t tag;
	} line_meta_t;

	typedef enum logic [1:0]
	{
		s_idle,
		s_compare_tag,
		s_write_back,
		s_allocate
	} ctrl_state_t;

	function automatic tag_t addr_tag(input addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(input addr_t a);
		return a[OFFSET_W +: INDEX_W];
	endfunction

	// word aligned line address, byte bits zero
	function automatic addr_t line_addr(input tag_t t, input index_t i);
		return {t, i, {OFFSET_W{1'b0}}};
	endfunction

endpackage

`default_nettype wire

//--- src/cache_lookup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_lookup_if
	import mem_pkg::*, cache_pkg::*;
();

	// latched request and update strobes
	index_t index;
	tag_t tag;
	word_t wr_word;
	logic write_hit;
	logic fill;

	// lookup results at the current index
	logic hit;
	logic victim_dirty;
	tag_t victim_tag;
	word_t victim_word;
	word_t rd_word;

	modport ctrl
	(
		output index, tag, wr_word, write_hit, fill,
		input hit, victim_dirty, victim_tag, victim_word, rd_word
	);

	modport store
	(
		input index, tag, wr_word, write_hit, fill,
		output hit, victim_dirty, victim_tag, victim_word, rd_word
	);

endinterface

`default_nettype wire

//--- src/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank
	import mem_pkg::*;
#(
	parameter type entry_t = word_t,
	parameter int DEPTH = 256
)
(
	input wire clk,
	input wire rst,
	input wire we,
	input wire [$clog2(DEPTH)-1:0] waddr,
	input wire entry_t wentry,
	input wire [$clog2(DEPTH)-1:0] raddr,
	output entry_t rentry
);

	entry_t mem [DEPTH];

	// cleared on reset so metadata starts out invalid
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end
		else if (we)
		begin
			mem[waddr] <= wentry;
		end
	end

	// asynchronous read
	assign rentry = mem[raddr];

	a_waddr_known: assert property (@(posedge clk) disable iff (!rst)
		we |-> !$isunknown(waddr))
		else $error("sram_bank write with unknown address");

endmodule

`default_nettype wire

//--- src/cache_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_store
	import mem_pkg::*, cache_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire word_t mem_rdata,
	cache_lookup_if.store lk
);

	line_meta_t meta_rd;
	line_meta_t meta_wr;
	word_t data_rd;
	word_t data_wr;
	logic bank_we;

	// fill installs a clean valid line from memory
	// write hit keeps the tag and marks the line dirty
	always_comb
	begin
		meta_wr = meta_rd;
		data_wr = lk.wr_word;
		if (lk.fill)
		begin
			meta_wr.valid = 1'b1;
			meta_wr.dirty = 1'b0;
			meta_wr.tag = lk.tag;
			data_wr = mem_rdata;
		end
		else
		begin
			meta_wr.dirty = 1'b1;
		end
	end

	assign bank_we = lk.fill | lk.write_hit;

	sram_bank #(
		.entry_t(line_meta_t),
		.DEPTH(LINES)
	) meta_bank_i (
		.clk(clk),
		.rst(rst),
		.we(bank_we),
		.waddr(lk.index),
		.wentry(meta_wr),
		.raddr(lk.index),
		.rentry(meta_rd)
	);

	sram_bank #(
		.entry_t(word_t),
		.DEPTH(LINES)
	) data_bank_i (
		.clk(clk),
		.rst(rst),
		.we(bank_we),
		.waddr(lk.index),
		.wentry(data_wr),
		.raddr(lk.index),
		.rentry(data_rd)
	);

	assign lk.hit = meta_rd.valid && (meta_rd.tag == lk.tag);
	// an invalid line never needs a write back
	assign lk.victim_dirty = meta_rd.valid && meta_rd.dirty;
	assign lk.victim_tag = meta_rd.tag;
	assign lk.victim_word = data_rd;
	assign lk.rd_word = data_rd;

	a_one_update: assert property (@(posedge clk) disable iff (!rst)
		!(lk.fill && lk.write_hit))
		else $error("fill and write_hit in the same cycle");

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
	import mem_pkg::*, cache_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire req,
	input wire we,
	input wire addr_t addr,
	input wire word_t wdata,
	input wire mem_ack,
	output logic ready,
	output logic mem_cs,
	output logic mem_we,
	output addr_t mem_addr,
	output word_t mem_wdata,
	cache_lookup_if.ctrl lk
);

	ctrl_state_t state;
	logic accept;
	logic req_we;
	addr_t req_addr;
	word_t req_wdata;

	// requests only taken while idle
	assign accept = (state == s_idle) && req;

	assign lk.index = addr_index(req_addr);
	assign lk.tag = addr_tag(req_addr);
	assign lk.wr_word = req_wdata;
	// memory word lands in the line on the ack edge
	assign lk.fill = (state == s_allocate) && mem_ack;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_we <= we;
			req_addr <= addr;
			req_wdata <= wdata;
		end
		if ((state == s_compare_tag) && !lk.hit)
		begin
			if (lk.victim_dirty)
				mem_addr <= line_addr(lk.victim_tag, lk.index);
			else
				mem_addr <= line_addr(lk.tag, lk.index);
			mem_wdata <= lk.victim_word;
		end
		else if ((state == s_write_back) && mem_ack)
		begin
			mem_addr <= line_addr(lk.tag, lk.index);
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			ready <= 1'b0;
			mem_cs <= 1'b0;
			mem_we <= 1'b0;
			lk.write_hit <= 1'b0;
		end
		else
		begin
			ready <= 1'b0;
			lk.write_hit <= 1'b0;
			case (state)
				s_idle:
				begin
					if (accept)
						state <= s_compare_tag;
				end
				s_compare_tag:
				begin
					if (lk.hit)
					begin
						ready <= 1'b1;
						lk.write_hit <= req_we;
						state <= s_idle;
					end
					else if (lk.victim_dirty)
					begin
						mem_cs <= 1'b1;
						mem_we <= 1'b1;
						state <= s_write_back;
					end
					else
					begin
						mem_cs <= 1'b1;
						mem_we <= 1'b0;
						state <= s_allocate;
					end
				end
				s_write_back:
				begin
					// victim is out, go fetch the new line
					if (mem_ack)
					begin
						mem_we <= 1'b0;
						state <= s_allocate;
					end
				end
				s_allocate:
				begin
					if (mem_ack)
					begin
						mem_cs <= 1'b0;
						state <= s_compare_tag;
					end
				end
				default:
				begin
					state <= s_idle;
				end
			endcase
		end
	end

	a_mem_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_cs && !mem_ack |=> mem_cs && $stable(mem_we) && $stable(mem_addr))
		else $error("memory request changed before ack");

	a_ready_not_busy: assert property (@(posedge clk) disable iff (!rst)
		!(ready && mem_cs))
		else $error("ready raised during a memory access");

endmodule

`default_nettype wire

//--- src/l1_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache_top
	import mem_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire req,
	input wire we,
	input wire addr_t addr,
	input wire word_t wdata,
	input wire mem_ack,
	input wire word_t mem_rdata,
	output wire ready,
	output wire word_t rdata,
	output wire mem_cs,
	output wire mem_we,
	output wire addr_t mem_addr,
	output wire word_t mem_wdata
);

	cache_lookup_if lk_if ();

	cache_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.mem_ack(mem_ack),
		.ready(ready),
		.mem_cs(mem_cs),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.lk(lk_if.ctrl)
	);

	// fill data goes straight from memory into the store
	cache_store store_i (
		.clk(clk),
		.rst(rst),
		.mem_rdata(mem_rdata),
		.lk(lk_if.store)
	);

	// read data is the data bank word at the latched index
	assign rdata = lk_if.rd_word;

endmodule

`default_nettype wire

//--- testbench/ext_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ext_mem_model
	import mem_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire cs,
	input wire we,
	input wire addr_t addr,
	input wire word_t wdata,
	output logic ack,
	output word_t rdata
);

	// sparse backing store, unwritten words read as zero
	word_t mem [addr_t];

	// every completed write, in order
	addr_t wr_addr_q [$];
	word_t wr_data_q [$];

	initial
	begin
		ack = 1'b0;
		rdata = '0;
	end

	// one operation per ack, request sampled mid cycle
	always @(negedge clk)
	begin : serve
		logic op_we;
		addr_t op_addr;
		word_t op_data;
		int delay;
		if (rst && cs)
		begin
			op_we = we;
			op_addr = addr;
			op_data = wdata;
			delay = $urandom_range(1, 6);
			repeat (delay)
				@(posedge clk);
			#2;
			ack = 1'b1;
			if (op_we)
			begin
				mem[op_addr] = op_data;
				wr_addr_q.push_back(op_addr);
				wr_data_q.push_back(op_data);
				// junk on the read bus, must not be stored
				rdata = ~op_data;
			end
			else if (mem.exists(op_addr))
				rdata = mem[op_addr];
			else
				rdata = '0;
			@(posedge clk);
			#2;
			ack = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache
	import mem_pkg::*, cache_pkg::*;
();

	localparam int TIMEOUT = 100;
	localparam int N_RANDOM = 400;

	logic clk;
	logic rst;
	logic req;
	logic we;
	addr_t addr;
	word_t wdata;
	wire ready;
	wire word_t rdata;
	wire mem_cs;
	wire mem_we;
	wire addr_t mem_addr;
	wire word_t mem_wdata;
	wire mem_ack;
	wire word_t mem_rdata;

	// reference view of the cache lines and of memory
	logic m_valid [LINES];
	logic m_dirty [LINES];
	tag_t m_tag [LINES];
	word_t m_word [LINES];
	word_t model_mem [addr_t];

	// few tags over few indexes, so lines conflict often
	tag_t tag_pool [4] = '{22'h0, 22'h1, 22'h2a5, 22'h3fffff};
	index_t index_pool [4] = '{8'h00, 8'h01, 8'h7f, 8'hff};

	l1_cache_top dut_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.ready(ready),
		.rdata(rdata),
		.mem_cs(mem_cs),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	ext_mem_model mem_i (
		.clk(clk),
		.rst(rst),
		.cs(mem_cs),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.ack(mem_ack),
		.rdata(mem_rdata)
	);

	initial
		clk = 1'b0;

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h",
				name, got, exp));
	endtask

	// one CPU access, predicted from the line model and checked on the fly
	task automatic run_access(input logic wr, input addr_t a, input word_t d);
		tag_t t;
		index_t i;
		addr_t line;
		logic hit;
		logic evict;
		int n_log;
		int cycles;
		logic done;
		logic saw_cs;
		logic saw_wr;
		addr_t rd_addr;
		t = a[31:10];
		i = a[9:2];
		line = {t, i, 2'b00};
		hit = m_valid[i] && (m_tag[i] == t);
		evict = !hit && m_valid[i] && m_dirty[i];
		n_log = mem_i.wr_addr_q.size();
		@(posedge clk);
		#2;
		req = 1'b1;
		we = wr;
		addr = a;
		wdata = d;
		@(posedge clk);
		#2;
		// scramble the bus so only the latched request counts
		req = 1'b0;
		we = $urandom_range(0, 1);
		addr = $urandom;
		wdata = $urandom;
		cycles = 0;
		done = 1'b0;
		saw_cs = 1'b0;
		saw_wr = 1'b0;
		rd_addr = '0;
		while (!done && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			if (mem_cs)
			begin
				saw_cs = 1'b1;
				if (mem_we)
					saw_wr = 1'b1;
				else
					rd_addr = mem_addr;
			end
			if (ready)
				done = 1'b1;
		end
		if (!done)
			stop_with_failure("timed out waiting for ready from the cache");
		if (hit)
		begin
			check_eq("ready latency", cycles, 2);
			check_eq("mem_cs on hit", saw_cs, 1'b0);
		end
		else
		begin
			check_eq("mem_cs on miss", saw_cs, 1'b1);
			check_eq("mem_we on miss", saw_wr, evict);
			check_eq("mem_addr read", rd_addr, line);
			check_eq("mem write count", mem_i.wr_addr_q.size() - n_log, evict);
			if (evict)
			begin
				check_eq("mem_addr write back", mem_i.wr_addr_q[n_log],
					{m_tag[i], i, 2'b00});
				check_eq("mem_wdata write back", mem_i.wr_data_q[n_log], m_word[i]);
				model_mem[{m_tag[i], i, 2'b00}] = m_word[i];
			end
			m_word[i] = model_mem.exists(line) ? model_mem[line] : '0;
			m_valid[i] = 1'b1;
			m_dirty[i] = 1'b0;
			m_tag[i] = t;
		end
		if (wr)
		begin
			m_word[i] = d;
			m_dirty[i] = 1'b1;
		end
		else
			check_eq("rdata", rdata, m_word[i]);
	endtask

	initial
	begin
		addr_t a0;
		addr_t b0;
		addr_t ra;
		logic [1:0] byte_bits;
		void'($urandom(32'hfde1));
		rst = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		for (int n = 0; n < LINES; n++)
		begin
			m_valid[n] = 1'b0;
			m_dirty[n] = 1'b0;
			m_tag[n] = '0;
			m_word[n] = '0;
		end
		repeat (5)
			@(posedge clk);
		#2;
		rst = 1'b1;
		@(negedge clk);
		check_eq("ready after reset", ready, 1'b0);
		check_eq("mem_cs after reset", mem_cs, 1'b0);
		check_eq("mem_we after reset", mem_we, 1'b0);

		// same index, two tags
		a0 = {22'h3, 8'h10, 2'b00};
		b0 = {22'h7, 8'h10, 2'b01};
		run_access(1'b0, a0, '0);
		run_access(1'b0, a0, '0);
		run_access(1'b1, a0, 32'hcafe_0001);
		run_access(1'b0, a0, '0);
		// dirty victim goes out before b0 comes in
		run_access(1'b0, b0, '0);
		run_access(1'b0, a0, '0);
		run_access(1'b1, b0, 32'h1234_5678);

		for (int n = 0; n < N_RANDOM; n++)
		begin
			byte_bits = $urandom_range(0, 3);
			ra = {tag_pool[$urandom_range(0, 3)], index_pool[$urandom_range(0, 3)], byte_bits};
			run_access($urandom_range(0, 1), ra, $urandom);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
src/mem_pkg.sv
src/cache_pkg.sv
src/cache_lookup_if.sv
src/sram_bank.sv
src/cache_store.sv
src/cache_ctrl.sv
src/l1_cache_top.sv
testbench/ext_mem_model.sv
testbench/tb_l1_cache.sv
